// File: filelist.f
design/core_pkg.sv
design/reg_file.sv
design/int_decode.sv
design/forward_unit.sv
design/int_execute.sv
design/pipeline_top.sv
bench/tb_pipeline_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_pipeline_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_pipeline_top.sv
module tb_pipeline_top import core_pkg::*; ();

    localparam int N_INSTR        = 400;
    localparam int TIMEOUT_CYCLES = N_INSTR * 3 + 50;

    // Instruction kinds used by the stimulus
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_XOR  = 4;
    localparam int K_SLT  = 5;
    localparam int K_ADDI = 6;
    localparam int K_XORI = 7;
    localparam int K_LUI  = 8;

    logic   clk;
    logic   rst_n;
    logic   instr_valid_i;
    instr_t instr_i;
    wrb_s   wrb_o;

    logic [31:0] lfsr_state;
    word_t       model_regs [8];
    wrb_s        exp_q [$];
    int          due_q [$];
    int          neg_count   = 0;
    int          cycle_count = 0;
    int          checks         = 0;
    int          err_value      = 0;
    int          err_unexpected = 0;
    int          err_missing    = 0;

    pipeline_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wrb_o         (wrb_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic instr_t encode(input int kind, input logic [2:0] rd,
                                      input logic [2:0] rs1, input logic [2:0] rs2,
                                      input logic [11:0] imm);
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        d  = {2'b00, rd};
        s1 = {2'b00, rs1};
        s2 = {2'b00, rs2};
        case (kind)
            K_ADD:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            K_XOR:   return {7'b0000000, s2, s1, 3'b100, d, 7'b0110011};
            K_SLT:   return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
            K_ADDI:  return {imm, s1, 3'b000, d, 7'b0010011};
            K_XORI:  return {imm, s1, 3'b100, d, 7'b0010011};
            default: return {imm, s1, 3'b000, d, 7'b0110111};
        endcase
    endfunction

    function automatic word_t expected_result(input int kind, input word_t a, input word_t b);
        case (kind)
            K_ADD, K_ADDI: return a + b;
            K_SUB:         return a - b;
            K_AND:         return a & b;
            K_OR:          return a | b;
            K_XOR:         return a ^ b;
            K_SLT:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:       return '0;
        endcase
    endfunction

    // Compare the writeback port against the head of the expected queue
    task automatic check_writeback();
        if (wrb_o.valid) begin
            checks++;
            assert (exp_q.size() > 0 && due_q[0] == neg_count) else begin
                $display("Unexpected writeback strobe for x%0d at time %0t", wrb_o.rd, $time);
                err_unexpected++;
            end
            if (exp_q.size() > 0) begin
                assert (wrb_o == exp_q[0]) else begin
                    $display("error: time %0t, wrb_o expected x%0d=%h, actual x%0d=%h",
                             $time, exp_q[0].rd, exp_q[0].data, wrb_o.rd, wrb_o.data);
                    err_value++;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end else begin
            assert (exp_q.size() == 0 || due_q[0] != neg_count) else begin
                $display("Missing writeback for x%0d at time %0t", exp_q[0].rd, $time);
                err_missing++;
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        neg_count++;
        check_writeback();
        instr_valid_i = 1'b0;
    endtask

    // Drive one instruction and update the register model in program order
    task automatic issue(input int kind, input logic [2:0] rd, input logic [2:0] rs1,
                         input logic [2:0] rs2, input logic [11:0] imm);
        word_t a;
        word_t b;
        wrb_s  exp;
        a = model_regs[rs1];
        b = (kind == K_ADDI) ? {{20{imm[11]}}, imm} : model_regs[rs2];
        instr_valid_i = 1'b1;
        instr_i       = encode(kind, rd, rs1, rs2, imm);
        if (kind <= K_ADDI && rd != 3'd0) begin
            exp.valid      = 1'b1;
            exp.rd         = {2'b00, rd};
            exp.data       = expected_result(kind, a, b);
            model_regs[rd] = exp.data;
            exp_q.push_back(exp);
            // Visible one falling edge after the second rising edge
            due_q.push_back(neg_count + 2);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout after %0d cycles, pipeline did not drain", TIMEOUT_CYCLES);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin
        int         gap;
        int         sel;
        int         kind;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        logic [11:0] imm;

        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr_state    = 32'd84556;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // Port must stay quiet until the first instruction
        repeat (4) next_cycle();

        // Negative immediate, signed SLT and back-to-back dependencies
        issue(K_ADDI, 3'd1, 3'd0, 3'd0, 12'hffb);
        next_cycle();
        issue(K_SLT, 3'd2, 3'd1, 3'd0, 12'h000);
        next_cycle();
        issue(K_SLT, 3'd3, 3'd0, 3'd1, 12'h000);
        next_cycle();
        issue(K_ADD, 3'd0, 3'd1, 3'd2, 12'h000);
        next_cycle();
        issue(K_XORI, 3'd4, 3'd1, 3'd0, 12'h0f0);
        next_cycle();
        issue(K_ADD, 3'd5, 3'd0, 3'd2, 12'h000);

        for (int n = 6; n < N_INSTR; n++) begin
            gap = int'(rand_bits(2)) % 3;
            repeat (gap) next_cycle();
            next_cycle();
            sel = int'(rand_bits(4));
            if (sel < 12) begin
                kind = sel % 6;
            end else if (sel < 14) begin
                kind = K_ADDI;
            end else if (sel == 14) begin
                kind = K_XORI;
            end else begin
                kind = K_LUI;
            end
            rd  = 3'(rand_bits(3));
            rs1 = 3'(rand_bits(3));
            rs2 = 3'(rand_bits(3));
            imm = 12'(rand_bits(12));
            issue(kind, rd, rs1, rs2, imm);
        end

        repeat (5) next_cycle();
        assert (exp_q.size() == 0) else begin
            $display("%0d expected writebacks never appeared", exp_q.size());
            err_missing += exp_q.size();
        end

        $display("Checks: %0d, value errors: %0d, unexpected strobes: %0d, missing strobes: %0d",
                 checks, err_value, err_unexpected, err_missing);
        if (err_value + err_unexpected + err_missing == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_pipeline_top

// File: design/pipeline_top.sv
module pipeline_top import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,

    // Instruction strobe, no back-pressure
    input  logic   instr_valid_i,
    input  instr_t instr_i,

    // Retired results
    output wrb_s   wrb_o
);

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    rs1_val;
    word_t    rs2_val;
    id2exe_s  id2exe;
    wrb_s     exe_fwd;
    wrb_s     wrb;

    int_decode decode_module (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_idx_o     (rs1_idx),
        .rs2_idx_o     (rs2_idx),
        .rs1_val_i     (rs1_val),
        .rs2_val_i     (rs2_val),
        .id2exe_o      (id2exe)
    );

    reg_file reg_file_module (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wrb_i      (wrb)
    );

    forward_unit forward_module (
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exe_fwd_i  (exe_fwd),
        .wrb_i      (wrb),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val)
    );

    int_execute execute_module (
        .clk       (clk),
        .rst_n     (rst_n),
        .id2exe_i  (id2exe),
        .exe_fwd_o (exe_fwd),
        .wrb_o     (wrb)
    );

    assign wrb_o = wrb;

endmodule : pipeline_top

// File: design/int_execute.sv
module int_execute import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  id2exe_s id2exe_i,

    // Combinational result for the bypass path
    output wrb_s    exe_fwd_o,
    // Registered writeback
    output wrb_s    wrb_o
);

    word_t alu_result;
    word_t op_a;
    word_t op_b;
    wrb_s  wrb_d;
    wrb_s  wrb_q;

    assign op_a = id2exe_i.operand_a;
    assign op_b = id2exe_i.operand_b;

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            // Signed compare, result is 0 or 1
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        wrb_d.valid = id2exe_i.valid;
        wrb_d.rd    = id2exe_i.rd;
        wrb_d.data  = alu_result;
    end

    assign exe_fwd_o = wrb_d;

    // Execute to writeback stage register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_q.valid <= 1'b0;
        end else begin
            wrb_q <= wrb_d;
        end
    end

    assign wrb_o = wrb_q;

endmodule : int_execute

// File: design/forward_unit.sv
module forward_unit import core_pkg::*; (
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,

    // Bypass sources
    input  wrb_s     exe_fwd_i,
    input  wrb_s     wrb_i,

    output word_t    rs1_val_o,
    output word_t    rs2_val_o
);

    // Execute holds the younger result, so it is checked first
    function automatic word_t resolve(
        input reg_idx_t idx,
        input word_t    rf_data,
        input wrb_s     exe,
        input wrb_s     wrb
    );
        if (idx == '0) begin
            return '0;
        end else if (exe.valid && (exe.rd == idx)) begin
            return exe.data;
        end else if (wrb.valid && (wrb.rd == idx)) begin
            return wrb.data;
        end
        return rf_data;
    endfunction

    assign rs1_val_o = resolve(rs1_idx_i, rs1_data_i, exe_fwd_i, wrb_i);
    assign rs2_val_o = resolve(rs2_idx_i, rs2_data_i, exe_fwd_i, wrb_i);

endmodule : forward_unit

// File: design/int_decode.sv
module int_decode import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     instr_valid_i,
    input  instr_t   instr_i,

    // Source indices out, resolved values back from forwarding
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  word_t    rs1_val_i,
    input  word_t    rs2_val_i,

    output id2exe_s  id2exe_o
);

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    alu_op_e    alu_op;
    logic       supported;
    logic       use_imm;
    id2exe_s    id2exe_d;
    id2exe_s    id2exe_q;

    // Field extraction
    assign opcode    = opcode_e'(instr_i[6:0]);
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];
    assign funct7    = instr_i[31:25];

    // I-type immediate, sign-extended
    assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        alu_op    = ALU_ADD;
        supported = 1'b0;
        use_imm   = 1'b0;

        case (opcode)
            OPCODE_OP: begin
                supported = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
                    {F7_ALT,  F3_ADD_SUB}: alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:     alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:      alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:     alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}:     alu_op = ALU_SLT;
                    default:               supported = 1'b0;
                endcase
            end
            OPCODE_OP_IMM: begin
                // Only ADDI among the immediate forms
                if (funct3 == F3_ADD_SUB) begin
                    supported = 1'b1;
                    use_imm   = 1'b1;
                end
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // Writes to x0 are dropped here so they never reach writeback
    always_comb begin
        id2exe_d.valid     = instr_valid_i && supported && (rd != '0);
        id2exe_d.alu_op    = alu_op;
        id2exe_d.rd        = rd;
        id2exe_d.operand_a = rs1_val_i;
        id2exe_d.operand_b = use_imm ? imm_i : rs2_val_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id2exe_q.valid <= 1'b0;
        end else begin
            id2exe_q <= id2exe_d;
        end
    end

    assign id2exe_o = id2exe_q;

endmodule : int_decode

// File: design/reg_file.sv
module reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,

    input  wrb_s     wrb_i
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrb_i.valid && (wrb_i.rd != '0)) begin
            regs[wrb_i.rd] <= wrb_i.data;
        end
    end

    // Combinational reads, x0 hard-wired to zero
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule : reg_file

// File: design/core_pkg.sv
package core_pkg;

    // Data path width
    localparam int unsigned XLEN = 32;

    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned INSTR_W   = 32;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [INSTR_W-1:0]   instr_t;

    // Major opcodes that the core accepts
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Issue bundle, decode to execute
    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        reg_idx_t rd;
        word_t    operand_a;
        word_t    operand_b;
    } id2exe_s;

    // Result bundle, used for bypass, writeback and register write
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wrb_s;

endpackage : core_pkg
